/* vlog.f */
+incdir+design
design/backend_pkg.sv
design/sync_fifo.sv
design/rob.sv
design/exec_pipe.sv
design/commit_stage.sv
design/ooo_backend_top.sv
test/tb_ooo_backend.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_ooo_backend
FLIST = vlog.f
OBJ   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

/* test/tb_ooo_backend.sv */
// testbench for the out-of-order back end
// clock, reset, random stimulus, program-order model and retire checks

`timescale 1ns/1ps
`include "backend_config.svh"

module tb_ooo_backend;
    import backend_pkg::*;

    localparam int N_ALU       = 40;
    localparam int N_BRANCH    = 30;
    localparam int N_MISPRED   = 6;
    localparam int N_ILLEGAL   = 4;
    localparam int STALL_MAX   = `ROB_SIZE + `ISSUE_DEPTH + `RETIRE_DEPTH;
    localparam int N_DISPATCH  = N_ALU + N_BRANCH + 4 * N_MISPRED + 3 * N_ILLEGAL
                                 + STALL_MAX + 6;
    localparam int CYCLE_LIMIT = 40 * N_DISPATCH;

    logic             clock        = 1'b0;
    logic             reset;
    logic             dispatch_valid;
    logic             dispatch_ready;
    addr_t            pc;
    areg_t            areg;
    preg_t            preg;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] offset;
    logic             cond_branch;
    logic             uncond_branch;
    logic             pred_taken;
    logic [1:0]       latency;
    logic             illegal;
    logic             halt;
    logic             retire_valid;
    logic             retire_ready = 1'b0;
    addr_t            retire_pc;
    areg_t            retire_areg;
    preg_t            retire_preg;
    logic             retire_cond_branch;
    logic             retire_uncond_branch;
    logic             retire_taken;
    addr_t            retire_target;
    logic             retire_mispred;
    logic             retire_illegal;
    logic             retire_halt;
    logic             halted;

    // program-order model
    retire_t exp_q [$];
    retire_t exp_rec;
    retire_t pending;
    logic    exp_valid;
    logic    wrong_path;
    logic    past_halt;
    logic    hold_retire;
    addr_t   next_pc;
    int      cycles;
    logic    retire_fire;

    assign retire_fire = retire_valid && retire_ready;

    ooo_backend_top i_dut (.*);

    always #20 clock = ~clock;

    // retire port stalls at random unless held low
    always @(negedge clock)
        retire_ready = hold_retire ? 1'b0 : ($urandom % 4 != 0);

    task automatic report_error(input string what);
        $display("** Error at %0t: %s", $time, what);
        $display("SIMULATION FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic report_timeout();
        $display("run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    endtask

    function automatic void refresh_expected();
        exp_valid = (exp_q.size() != 0);
        if (exp_valid)
            exp_rec = exp_q[0];
    endfunction

    // retire record predicted from the instruction now on the dispatch port
    function automatic retire_t model_record();
        retire_t r;
        logic    tk;
        r.pc            = pc;
        r.areg          = areg;
        r.preg          = preg;
        r.cond_branch   = cond_branch;
        r.uncond_branch = uncond_branch;
        r.illegal       = illegal;
        r.halt          = halt;
        tk              = uncond_branch || (cond_branch && src_a == src_b);
        r.taken         = (illegal || halt) ? 1'b0 : tk;
        r.target        = (illegal || halt) ? '0 : (tk ? pc + offset : pc + 32'd4);
        r.mispred       = !(illegal || halt) && (cond_branch || uncond_branch)
                          && (tk != pred_taken);
        return r;
    endfunction

    task automatic drive_inst(input addr_t a, input addr_t b, input logic cond,
                              input logic uncond, input logic pred, input logic ill,
                              input logic hlt);
        pc            = next_pc;
        areg          = areg_t'($urandom);
        preg          = preg_t'($urandom);
        src_a         = a;
        src_b         = b;
        offset        = addr_t'($urandom % 64) * 4;
        cond_branch   = cond;
        uncond_branch = uncond;
        pred_taken    = pred;
        latency       = 2'($urandom);
        illegal       = ill;
        halt          = hlt;
        pending       = model_record();
    endtask

    task automatic drive_alu();
        drive_inst(addr_t'($urandom % 4), addr_t'($urandom % 4), 1'b0, 1'b0,
                   1'($urandom), 1'b0, 1'b0);
    endtask

    // called at the edge where the handshake happened
    // nothing behind a retired halt is ever expected
    task automatic record_dispatch();
        if (!wrong_path && !past_halt) begin
            exp_q.push_back(pending);
            if (pending.mispred)
                wrong_path = 1'b1;
            if (pending.halt)
                past_halt = 1'b1;
        end
        next_pc = next_pc + 4;
        refresh_expected();
    endtask

    task automatic dispatch_one(input addr_t a, input addr_t b, input logic cond,
                                input logic uncond, input logic pred, input logic ill,
                                input logic hlt);
        @(negedge clock);
        drive_inst(a, b, cond, uncond, pred, ill, hlt);
        dispatch_valid = 1'b1;
        while (!dispatch_ready)
            @(negedge clock);
        @(posedge clock);
        record_dispatch();
    endtask

    task automatic alu_op();
        dispatch_one(addr_t'($urandom % 4), addr_t'($urandom % 4), 1'b0, 1'b0,
                     1'($urandom), 1'b0, 1'b0);
    endtask

    task automatic branch_op(input logic uncond, input logic wrong);
        addr_t a;
        addr_t b;
        logic  tk;
        a  = addr_t'($urandom % 4);
        b  = addr_t'($urandom % 4);
        tk = uncond || (a == b);
        dispatch_one(a, b, !uncond, uncond, wrong ? !tk : tk, 1'b0, 1'b0);
    endtask

    task automatic drain();
        @(negedge clock);
        dispatch_valid = 1'b0;
        while (exp_q.size() != 0 || wrong_path)
            @(negedge clock);
        repeat (8) @(negedge clock);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // retire bookkeeping and checks
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            report_timeout();
        end else if (!reset && retire_fire && exp_valid) begin
            // the mispredicted branch itself ends the wrong path
            if (exp_q[0].mispred)
                wrong_path = 1'b0;
            void'(exp_q.pop_front());
            refresh_expected();
        end
    end

    assert property (@(posedge clock) disable iff (reset) retire_fire |-> exp_valid)
        else report_error("retire with no instruction expected");
    assert property (@(posedge clock) disable iff (reset)
        retire_fire && exp_valid |-> retire_pc == exp_rec.pc)
        else report_error("retire_pc mismatch");
    assert property (@(posedge clock) disable iff (reset)
        retire_fire && exp_valid |-> retire_areg == exp_rec.areg)
        else report_error("retire_areg mismatch");
    assert property (@(posedge clock) disable iff (reset)
        retire_fire && exp_valid |-> retire_preg == exp_rec.preg)
        else report_error("retire_preg mismatch");
    assert property (@(posedge clock) disable iff (reset)
        retire_fire && exp_valid |-> retire_cond_branch == exp_rec.cond_branch)
        else report_error("retire_cond_branch mismatch");
    assert property (@(posedge clock) disable iff (reset)
        retire_fire && exp_valid |-> retire_uncond_branch == exp_rec.uncond_branch)
        else report_error("retire_uncond_branch mismatch");
    assert property (@(posedge clock) disable iff (reset)
        retire_fire && exp_valid |-> retire_taken == exp_rec.taken)
        else report_error("retire_taken mismatch");
    assert property (@(posedge clock) disable iff (reset)
        retire_fire && exp_valid |-> retire_target == exp_rec.target)
        else report_error("retire_target mismatch");
    assert property (@(posedge clock) disable iff (reset)
        retire_fire && exp_valid |-> retire_mispred == exp_rec.mispred)
        else report_error("retire_mispred mismatch");
    assert property (@(posedge clock) disable iff (reset)
        retire_fire && exp_valid |-> retire_illegal == exp_rec.illegal)
        else report_error("retire_illegal mismatch");
    assert property (@(posedge clock) disable iff (reset)
        retire_fire && exp_valid |-> retire_halt == exp_rec.halt)
        else report_error("retire_halt mismatch");

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int n_wrong;
        int accepted;
        int stall;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        pc             = '0;
        areg           = '0;
        preg           = '0;
        src_a          = '0;
        src_b          = '0;
        offset         = '0;
        cond_branch    = 1'b0;
        uncond_branch  = 1'b0;
        pred_taken     = 1'b0;
        latency        = '0;
        illegal        = 1'b0;
        halt           = 1'b0;
        hold_retire    = 1'b0;
        wrong_path     = 1'b0;
        past_halt      = 1'b0;
        next_pc        = 32'h0000_1000;
        cycles         = 0;
        exp_valid      = 1'b0;
        exp_rec        = '0;
        void'($urandom(32'h30025479));
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        assert (dispatch_ready && !halted && !retire_valid)
            else report_error("outputs wrong after reset");

        // plain ALU traffic
        repeat (N_ALU) alu_op();

        // branches with correct predictions mixed in
        for (int i = 0; i < N_BRANCH; i++) begin
            case ($urandom % 3)
                0: alu_op();
                1: branch_op(1'b0, 1'b0);
                default: branch_op(1'b1, 1'b0);
            endcase
        end

        // mispredict, then a wrong path that must vanish
        repeat (N_MISPRED) begin
            drain();
            n_wrong = 1 + $urandom % 3;
            branch_op(1'($urandom), 1'b1);
            repeat (n_wrong) alu_op();
            drain();
        end

        // illegal between two ALU ops
        repeat (N_ILLEGAL) begin
            alu_op();
            dispatch_one('0, '0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
            alu_op();
        end

        // retire port stalled until dispatch backs up
        drain();
        @(posedge clock);
        hold_retire = 1'b1;
        accepted    = 0;
        stall       = 0;
        @(negedge clock);
        drive_alu();
        dispatch_valid = 1'b1;
        while (stall < 16 && accepted <= STALL_MAX) begin
            if (dispatch_ready) begin
                @(posedge clock);
                record_dispatch();
                accepted = accepted + 1;
                stall    = 0;
                @(negedge clock);
                drive_alu();
            end else begin
                stall = stall + 1;
                @(negedge clock);
            end
        end
        assert (accepted <= STALL_MAX && stall >= 16)
            else report_error("dispatch_ready did not fall under back-pressure");
        dispatch_valid = 1'b0;
        @(posedge clock);
        hold_retire = 1'b0;
        drain();

        // halt closes dispatch and commit
        // the retire FIFO is held full so younger ops queue up behind the halt
        @(posedge clock);
        hold_retire = 1'b1;
        repeat (2) alu_op();
        dispatch_one('0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        repeat (2) alu_op();
        @(posedge clock);
        hold_retire = 1'b0;
        drain();
        assert (halted) else report_error("halted low after halt retired");
        drive_alu();
        dispatch_valid = 1'b1;
        repeat (20) begin
            @(negedge clock);
            assert (halted && !dispatch_ready)
                else report_error("dispatch open after halt");
        end
        dispatch_valid = 1'b0;
        repeat (4) @(negedge clock);

        if (exp_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_error("instructions missing at end of run");
        end
    end

endmodule

/* design/ooo_backend_top.sv */
// top level of the out-of-order back end
// reorder buffer, issue queue, execution pipe and commit stage

`timescale 1ns/1ps
`include "backend_config.svh"

module ooo_backend_top (
    input  logic               clock,
    input  logic               reset,
    // dispatch port
    input  logic               dispatch_valid,
    output logic               dispatch_ready,
    input  backend_pkg::addr_t pc,
    input  backend_pkg::areg_t areg,
    input  backend_pkg::preg_t preg,
    input  logic [`XLEN-1:0]   src_a,
    input  logic [`XLEN-1:0]   src_b,
    input  logic [`XLEN-1:0]   offset,
    input  logic               cond_branch,
    input  logic               uncond_branch,
    input  logic               pred_taken,
    input  logic [1:0]         latency,
    input  logic               illegal,
    input  logic               halt,
    // retire port
    output logic               retire_valid,
    input  logic               retire_ready,
    output backend_pkg::addr_t retire_pc,
    output backend_pkg::areg_t retire_areg,
    output backend_pkg::preg_t retire_preg,
    output logic               retire_cond_branch,
    output logic               retire_uncond_branch,
    output logic               retire_taken,
    output backend_pkg::addr_t retire_target,
    output logic               retire_mispred,
    output logic               retire_illegal,
    output logic               retire_halt,
    output logic               halted
);
    import backend_pkg::*;

    logic      issue_push_valid;
    logic      issue_push_ready;
    exec_req_t issue_push_data;
    logic      issue_valid;
    logic      issue_ready;
    exec_req_t issue_data;
    logic      cpl_valid;
    rob_tag_t  cpl_tag;
    logic      cpl_taken;
    addr_t     cpl_target;
    logic      cpl_mispred;
    logic      head_valid;
    retire_t   head_data;
    logic      commit_fire;
    logic      flush;

    ////////////////////////////////////////////////////////////////////////////
    // dispatch, issue, execute, commit
    ////////////////////////////////////////////////////////////////////////////

    rob i_rob (.*);

    sync_fifo #(
        .payload_t (exec_req_t),
        .DEPTH     (`ISSUE_DEPTH)
    ) i_issue_fifo (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (issue_push_valid),
        .in_ready  (issue_push_ready),
        .in_data   (issue_push_data),
        .out_valid (issue_valid),
        .out_ready (issue_ready),
        .out_data  (issue_data)
    );

    exec_pipe i_exec_pipe (.*);

    commit_stage i_commit_stage (.*);

endmodule

/* design/commit_stage.sv */
// in-order commit from the reorder buffer head
// halt latch, flush decision and registered retire port

`timescale 1ns/1ps
`include "backend_config.svh"

module commit_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 head_valid,
    input  backend_pkg::retire_t head_data,
    output logic                 commit_fire,
    output logic                 flush,
    output logic                 halted,
    output logic                 retire_valid,
    input  logic                 retire_ready,
    output backend_pkg::addr_t   retire_pc,
    output backend_pkg::areg_t   retire_areg,
    output backend_pkg::preg_t   retire_preg,
    output logic                 retire_cond_branch,
    output logic                 retire_uncond_branch,
    output logic                 retire_taken,
    output backend_pkg::addr_t   retire_target,
    output logic                 retire_mispred,
    output logic                 retire_illegal,
    output logic                 retire_halt
);
    import backend_pkg::*;

    logic    fifo_ready;
    retire_t retire_data;

    assign commit_fire = head_valid && fifo_ready && !halted;
    // a mispredicted branch takes its younger entries with it
    assign flush       = commit_fire && head_data.mispred;

    always_ff @(posedge clock) begin
        if (reset)
            halted <= 1'b0;
        else if (commit_fire && head_data.halt)
            halted <= 1'b1;
    end

    sync_fifo #(
        .payload_t (retire_t),
        .DEPTH     (`RETIRE_DEPTH)
    ) i_retire_fifo (
        .clock     (clock),
        .reset     (reset),
        .flush     (1'b0),
        .in_valid  (commit_fire),
        .in_ready  (fifo_ready),
        .in_data   (head_data),
        .out_valid (retire_valid),
        .out_ready (retire_ready),
        .out_data  (retire_data)
    );

    assign retire_pc            = retire_data.pc;
    assign retire_areg          = retire_data.areg;
    assign retire_preg          = retire_data.preg;
    assign retire_cond_branch   = retire_data.cond_branch;
    assign retire_uncond_branch = retire_data.uncond_branch;
    assign retire_taken         = retire_data.taken;
    assign retire_target        = retire_data.target;
    assign retire_mispred       = retire_data.mispred;
    assign retire_illegal       = retire_data.illegal;
    assign retire_halt          = retire_data.halt;

endmodule

/* design/exec_pipe.sv */
// execution pipe with a few in-flight slots
// per-instruction latency countdown and branch resolution

`timescale 1ns/1ps
`include "backend_config.svh"

module exec_pipe (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   issue_valid,
    output logic                   issue_ready,
    input  backend_pkg::exec_req_t issue_data,
    output logic                   cpl_valid,
    output backend_pkg::rob_tag_t  cpl_tag,
    output logic                   cpl_taken,
    output backend_pkg::addr_t     cpl_target,
    output logic                   cpl_mispred
);
    import backend_pkg::*;

    localparam int SLOT_W = (`EXEC_SLOTS > 1) ? $clog2(`EXEC_SLOTS) : 1;

    logic              slot_busy [`EXEC_SLOTS];
    exec_req_t         slot_req  [`EXEC_SLOTS];
    logic [1:0]        slot_wait [`EXEC_SLOTS];
    logic [SLOT_W-1:0] free_idx;
    logic [SLOT_W-1:0] done_idx;
    exec_req_t         done_req;
    logic              is_branch;

    // lowest free slot and lowest finished slot
    always_comb begin
        issue_ready = 1'b0;
        free_idx    = '0;
        cpl_valid   = 1'b0;
        done_idx    = '0;
        for (int i = `EXEC_SLOTS - 1; i >= 0; i--) begin
            if (!slot_busy[i]) begin
                issue_ready = 1'b1;
                free_idx    = SLOT_W'(i);
            end
            if (slot_busy[i] && slot_wait[i] == 2'd0) begin
                cpl_valid = 1'b1;
                done_idx  = SLOT_W'(i);
            end
        end
    end

    // branch resolution on the completing request
    assign done_req    = slot_req[done_idx];
    assign is_branch   = done_req.cond_branch || done_req.uncond_branch;
    assign cpl_tag     = done_req.tag;
    assign cpl_taken   = done_req.uncond_branch ||
                         (done_req.cond_branch && (done_req.src_a == done_req.src_b));
    assign cpl_target  = cpl_taken ? done_req.pc + done_req.offset : done_req.pc + `XLEN'd4;
    assign cpl_mispred = is_branch && (cpl_taken != done_req.pred_taken);

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            for (int i = 0; i < `EXEC_SLOTS; i++)
                slot_busy[i] <= 1'b0;
        end else begin
            // finished slots hold at zero until they win the completion port
            for (int i = 0; i < `EXEC_SLOTS; i++) begin
                if (slot_busy[i] && slot_wait[i] != 2'd0)
                    slot_wait[i] <= slot_wait[i] - 1'b1;
            end
            if (cpl_valid)
                slot_busy[done_idx] <= 1'b0;
            if (issue_valid && issue_ready) begin
                slot_busy[free_idx] <= 1'b1;
                slot_req[free_idx]  <= issue_data;
                slot_wait[free_idx] <= issue_data.latency;
            end
        end
    end

endmodule

/* design/rob.sv */
// reorder buffer with dispatch allocation
// completion marking, head presentation and flush

`timescale 1ns/1ps
`include "backend_config.svh"

module rob (
    input  logic                   clock,
    input  logic                   reset,
    // dispatch port
    input  logic                   dispatch_valid,
    output logic                   dispatch_ready,
    input  backend_pkg::addr_t     pc,
    input  backend_pkg::areg_t     areg,
    input  backend_pkg::preg_t     preg,
    input  logic [`XLEN-1:0]       src_a,
    input  logic [`XLEN-1:0]       src_b,
    input  logic [`XLEN-1:0]       offset,
    input  logic                   cond_branch,
    input  logic                   uncond_branch,
    input  logic                   pred_taken,
    input  logic [1:0]             latency,
    input  logic                   illegal,
    input  logic                   halt,
    // push side of the issue queue
    output logic                   issue_push_valid,
    input  logic                   issue_push_ready,
    output backend_pkg::exec_req_t issue_push_data,
    // completions from the pipe
    input  logic                   cpl_valid,
    input  backend_pkg::rob_tag_t  cpl_tag,
    input  logic                   cpl_taken,
    input  backend_pkg::addr_t     cpl_target,
    input  logic                   cpl_mispred,
    // head towards commit
    output logic                   head_valid,
    output backend_pkg::retire_t   head_data,
    input  logic                   commit_fire,
    input  logic                   flush,
    input  logic                   halted
);
    import backend_pkg::*;

    retire_t           entries  [`ROB_SIZE];
    logic              executed [`ROB_SIZE];
    rob_tag_t          head;
    rob_tag_t          tail;
    logic [`ROB_LEN:0] count;
    logic              dispatch_fire;
    logic              needs_exec;

    function automatic rob_tag_t next_tag(input rob_tag_t tag);
        return (tag == `ROB_SIZE - 1) ? '0 : tag + 1'b1;
    endfunction

    assign dispatch_ready   = (count != `ROB_SIZE) && issue_push_ready && !halted;
    assign dispatch_fire    = dispatch_valid && dispatch_ready;
    // illegal and halt entries never see the pipe
    assign needs_exec       = !(illegal || halt);
    assign issue_push_valid = dispatch_fire && needs_exec;

    assign head_valid = (count != 0) && executed[head];
    assign head_data  = entries[head];

    always_comb begin
        issue_push_data.tag           = tail;
        issue_push_data.pc            = pc;
        issue_push_data.src_a         = src_a;
        issue_push_data.src_b         = src_b;
        issue_push_data.offset        = offset;
        issue_push_data.cond_branch   = cond_branch;
        issue_push_data.uncond_branch = uncond_branch;
        issue_push_data.pred_taken    = pred_taken;
        issue_push_data.latency       = latency;
    end

    ////////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // everything younger than the head is gone
            head  <= tail;
            count <= '0;
        end else begin
            if (dispatch_fire)
                tail <= next_tag(tail);
            if (commit_fire)
                head <= next_tag(head);
            if (dispatch_fire && !commit_fire)
                count <= count + 1'b1;
            else if (commit_fire && !dispatch_fire)
                count <= count - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!flush) begin
            if (dispatch_fire) begin
                entries[tail].pc            <= pc;
                entries[tail].areg          <= areg;
                entries[tail].preg          <= preg;
                entries[tail].cond_branch   <= cond_branch;
                entries[tail].uncond_branch <= uncond_branch;
                entries[tail].taken         <= 1'b0;
                entries[tail].target        <= '0;
                entries[tail].mispred       <= 1'b0;
                entries[tail].illegal       <= illegal;
                entries[tail].halt          <= halt;
                executed[tail]              <= !needs_exec;
            end
            // resolved branch info arrives with the completion
            if (cpl_valid) begin
                executed[cpl_tag]        <= 1'b1;
                entries[cpl_tag].taken   <= cpl_taken;
                entries[cpl_tag].target  <= cpl_target;
                entries[cpl_tag].mispred <= cpl_mispred;
            end
        end
    end

endmodule

/* design/sync_fifo.sv */
// synchronous FIFO with valid/ready on both sides
// payload type is a parameter, flush empties the queue

`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t                   mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       push;
    logic                       pop;

    assign in_ready  = (count != DEPTH);
    assign out_valid = (count != 0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                mem[wr_ptr] <= in_data;
                wr_ptr      <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

/* design/backend_pkg.sv */
// shared types of the back end
// tags, addresses, register indices, issue payload and retire record

`include "backend_config.svh"

package backend_pkg;

    typedef logic [`ROB_LEN-1:0] rob_tag_t;
    typedef logic [`XLEN-1:0]    addr_t;
    typedef logic [4:0]          areg_t;
    typedef logic [`PRF_LEN-1:0] preg_t;

    // request handed from the issue queue to the pipe
    typedef struct packed {
        rob_tag_t         tag;
        addr_t            pc;
        logic [`XLEN-1:0] src_a;
        logic [`XLEN-1:0] src_b;
        logic [`XLEN-1:0] offset;
        logic             cond_branch;
        logic             uncond_branch;
        logic             pred_taken;
        logic [1:0]       latency;
    } exec_req_t;

    // one retired instruction
    typedef struct packed {
        addr_t pc;
        areg_t areg;
        preg_t preg;
        logic  cond_branch;
        logic  uncond_branch;
        logic  taken;
        addr_t target;
        logic  mispred;
        logic  illegal;
        logic  halt;
    } retire_t;

endpackage

/* design/backend_config.svh */
// sizing macros for the out-of-order back end
// buffer sizes, tag widths and FIFO depths

`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// datapath and tag widths
`define XLEN         32
`define ROB_SIZE     8
`define ROB_LEN      3
`define PRF_LEN      6

// pipe and queue sizes
`define EXEC_SLOTS   4
`define ISSUE_DEPTH  4
`define RETIRE_DEPTH 2

`endif
